//--- common/lsuPkg.sv
package lsuPkg;

	////////////////////////////////////////////////////////////////////////////
	// data and bus types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] word_t; // data or address word
	typedef logic [3:0] strobe_t; // one enable per byte lane
	typedef logic [1:0] busSize_t; // sram-like size code

	// access width as the caller gives it
	typedef enum logic [1:0] {
		memWord = 2'd0,
		memHalf = 2'd1,
		memByte = 2'd2
	} memWidth_t;

	localparam busSize_t sizeByte = 2'd0;
	localparam busSize_t sizeHalf = 2'd1;
	localparam busSize_t sizeWord = 2'd2;

	////////////////////////////////////////////////////////////////////////////
	// exceptions
	////////////////////////////////////////////////////////////////////////////

	typedef logic [4:0] excCode_t;

	localparam excCode_t excAdEL = 5'd4; // address error on load
	localparam excCode_t excAdES = 5'd5; // address error on store

	// kseg0/kseg1 style fixed mapping, top three bits dropped
	localparam word_t defaultPhysMask = 32'h1fffffff;

endpackage

//--- lsu/requestBuilder.sv
`timescale 1ns/1ps

module requestBuilder #(
	parameter lsuPkg::word_t physMask = lsuPkg::defaultPhysMask
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic isStore,
	input lsuPkg::memWidth_t width,
	input logic signExt,
	input lsuPkg::word_t vAddr,
	input lsuPkg::word_t storeData,
	output logic issue,
	output logic reqIsStore,
	output lsuPkg::memWidth_t reqWidth,
	output logic reqSignExt,
	output logic [1:0] reqLane,
	output logic excValid,
	output lsuPkg::excCode_t excCode,
	output lsuPkg::word_t badVAddr,
	output lsuPkg::word_t dataAddr,
	output logic dataWr,
	output lsuPkg::strobe_t dataWstrb,
	output lsuPkg::word_t dataWdata,
	output lsuPkg::busSize_t dataSize
);

	import lsuPkg::*;

	logic accept;
	logic misaligned;
	word_t reqAddr; // virtual address of the held request
	word_t reqData; // raw store data, lanes built below

	assign accept = start && !busy; // starts while busy are dropped

	always_comb begin
		case (width)
			memWord: misaligned = (vAddr[1:0] != 2'b00);
			memHalf: misaligned = vAddr[0];
			default: misaligned = 1'b0; // bytes are always aligned
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// request registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			issue <= 1'b0;
			excValid <= 1'b0;
			reqIsStore <= 1'b0;
		end else begin
			issue <= accept && !misaligned;
			excValid <= accept && misaligned; // fault goes back, bus untouched
			if (accept)
				reqIsStore <= isStore;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			reqWidth <= width;
			reqSignExt <= signExt;
			reqAddr <= vAddr;
			reqData <= storeData;
		end
	end

	assign reqLane = reqAddr[1:0];
	assign excCode = reqIsStore ? excAdES : excAdEL;
	assign badVAddr = reqAddr;

	////////////////////////////////////////////////////////////////////////////
	// bus fields
	////////////////////////////////////////////////////////////////////////////

	assign dataAddr = reqAddr & physMask; // fixed virtual to physical map
	assign dataWr = reqIsStore;

	always_comb begin
		case (reqWidth)
			memWord: begin
				dataSize = sizeWord;
				dataWdata = reqData;
				dataWstrb = 4'b1111;
			end
			memHalf: begin
				dataSize = sizeHalf;
				dataWdata = {2{reqData[15:0]}};
				dataWstrb = reqLane[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				dataSize = sizeByte;
				dataWdata = {4{reqData[7:0]}};
				dataWstrb = 4'b0001 << reqLane; // one-hot by byte offset
			end
		endcase
		if (!reqIsStore)
			dataWstrb = 4'b0000; // loads write nothing
	end

endmodule

//--- lsu/busSequencer.sv
`timescale 1ns/1ps

module busSequencer (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic dataAddrOk,
	input logic dataDataOk,
	output logic busy,
	output logic dataReq,
	output logic capture,
	output logic done
);

	typedef enum logic [1:0] {
		stIdle = 2'd0,
		stAddr = 2'd1, // request held until accepted
		stData = 2'd2  // waiting for read or write data
	} seqState_t;

	seqState_t state;
	seqState_t stateNext;

	////////////////////////////////////////////////////////////////////////////
	// request / address / data phases
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		stateNext = state;
		case (state)
			stIdle: begin
				if (issue)
					stateNext = stAddr;
			end
			stAddr: begin
				if (dataAddrOk)
					stateNext = stData; // address taken at this edge
			end
			stData: begin
				if (dataDataOk)
					stateNext = stIdle;
			end
			default: stateNext = stIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= stIdle;
		else
			state <= stateNext;
	end

	assign dataReq = (state == stAddr);
	assign capture = (state == stData) && dataDataOk;

	// issue cycle counts as busy so a start right behind it is dropped
	assign busy = (state != stIdle) || issue;

	always_ff @(posedge clk) begin
		if (reset)
			done <= 1'b0;
		else
			done <= capture; // one cycle, busy already low
	end

endmodule

//--- lsu/loadAlign.sv
`timescale 1ns/1ps

module loadAlign (
	input logic clk,
	input logic reset,
	input logic capture,
	input logic reqIsStore,
	input lsuPkg::memWidth_t reqWidth,
	input logic reqSignExt,
	input logic [1:0] reqLane,
	input lsuPkg::word_t dataRdata,
	output lsuPkg::word_t loadData
);

	import lsuPkg::*;

	logic [15:0] halfSel;
	logic [7:0] byteSel;
	word_t extended;

	assign halfSel = reqLane[1] ? dataRdata[31:16] : dataRdata[15:0];

	always_comb begin
		case (reqLane)
			2'd0: byteSel = dataRdata[7:0];
			2'd1: byteSel = dataRdata[15:8];
			2'd2: byteSel = dataRdata[23:16];
			default: byteSel = dataRdata[31:24];
		endcase
	end

	// sign or zero fill above the selected lane
	always_comb begin
		case (reqWidth)
			memWord: extended = dataRdata;
			memHalf: extended = {{16{reqSignExt & halfSel[15]}}, halfSel};
			default: extended = {{24{reqSignExt & byteSel[7]}}, byteSel};
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			loadData <= '0;
		else if (capture && !reqIsStore)
			loadData <= extended; // stores keep the last load value
	end

endmodule

//--- hdl/lsuTop.sv
`timescale 1ns/1ps

module lsuTop #(
	parameter lsuPkg::word_t physMask = lsuPkg::defaultPhysMask
) (
	input logic clk,
	input logic reset,

	// caller side
	input logic start,
	input logic isStore,
	input lsuPkg::memWidth_t width,
	input logic signExt,
	input lsuPkg::word_t vAddr,
	input lsuPkg::word_t storeData,
	output logic busy,
	output logic done,
	output lsuPkg::word_t loadData,
	output logic excValid,
	output lsuPkg::excCode_t excCode,
	output lsuPkg::word_t badVAddr,

	// sram-like data bus
	output logic dataReq,
	output logic dataWr,
	output lsuPkg::busSize_t dataSize,
	output lsuPkg::word_t dataAddr,
	output lsuPkg::strobe_t dataWstrb,
	output lsuPkg::word_t dataWdata,
	input lsuPkg::word_t dataRdata,
	input logic dataAddrOk,
	input logic dataDataOk
);

	import lsuPkg::*;

	logic issue; // one cycle, aligned request ready
	logic capture; // read data sampled this cycle
	logic reqIsStore;
	memWidth_t reqWidth;
	logic reqSignExt;
	logic [1:0] reqLane; // byte offset within the word

	requestBuilder #(
		.physMask(physMask)
	) u_requestBuilder (
		.clk(clk),
		.reset(reset),
		.start(start),
		.busy(busy),
		.isStore(isStore),
		.width(width),
		.signExt(signExt),
		.vAddr(vAddr),
		.storeData(storeData),
		.issue(issue),
		.reqIsStore(reqIsStore),
		.reqWidth(reqWidth),
		.reqSignExt(reqSignExt),
		.reqLane(reqLane),
		.excValid(excValid),
		.excCode(excCode),
		.badVAddr(badVAddr),
		.dataAddr(dataAddr),
		.dataWr(dataWr),
		.dataWstrb(dataWstrb),
		.dataWdata(dataWdata),
		.dataSize(dataSize)
	);

	busSequencer u_busSequencer (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.dataAddrOk(dataAddrOk),
		.dataDataOk(dataDataOk),
		.busy(busy),
		.dataReq(dataReq),
		.capture(capture),
		.done(done)
	);

	loadAlign u_loadAlign (
		.clk(clk),
		.reset(reset),
		.capture(capture),
		.reqIsStore(reqIsStore),
		.reqWidth(reqWidth),
		.reqSignExt(reqSignExt),
		.reqLane(reqLane),
		.dataRdata(dataRdata),
		.loadData(loadData)
	);

endmodule

//--- tb/lsuTb.sv
`timescale 1ns/1ps

module lsuTb;

	import lsuPkg::*;

	localparam word_t physMask = 32'h1fffffff;
	localparam int numEntries = 15;
	localparam int entryLimit = 40; // cycles allowed per access
	localparam int timeoutCycles = entryLimit * numEntries + 100;

	typedef struct {
		logic isStore;
		memWidth_t width;
		logic signExt;
		word_t addr;
		word_t data;
		logic fault;
		excCode_t code;
		strobe_t strb;
		word_t busData; // replicated store lanes
		word_t result; // extended load value
	} entry_t;

	logic clk;
	logic reset;
	logic start;
	logic isStore;
	memWidth_t width;
	logic signExt;
	word_t vAddr;
	word_t storeData;
	logic busy;
	logic done;
	word_t loadData;
	logic excValid;
	excCode_t excCode;
	word_t badVAddr;
	logic dataReq;
	logic dataWr;
	busSize_t dataSize;
	word_t dataAddr;
	strobe_t dataWstrb;
	word_t dataWdata;
	word_t dataRdata = '0;
	logic dataAddrOk = 1'b0;
	logic dataDataOk = 1'b0;

	entry_t vec[numEntries];
	word_t mem[16];
	word_t rngState;
	word_t busAddr; // request as seen by the memory model
	busSize_t busSize;
	strobe_t busStrb;
	word_t busData;
	logic busWr;
	int memPhase;
	int waitLeft;
	int reqCount;
	int doneCount;
	int busErrors;
	int errorCount;
	int passCount;
	int cycleCount;
	int i;

	lsuTop #(
		.physMask(physMask)
	) u_lsuTop (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: run did not finish within %0d cycles", timeoutCycles);
		$display("Test failures found");
		$finish;
	end

	function automatic word_t xorshift(input word_t x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic busSize_t sizeFor(input memWidth_t w);
		case (w)
			memWord: return 2'd2;
			memHalf: return 2'd1;
			default: return 2'd0;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// memory model with random accept and data delays of 0 to 3 cycles
	////////////////////////////////////////////////////////////////////////////

	initial begin
		rngState = 32'h3b82;
		memPhase = 0;
		waitLeft = 0;
		reqCount = 0;
		doneCount = 0;
		busErrors = 0;
		for (int a = 0; a < 16; a++)
			mem[a] = 32'h9e3779b9 * (a + 1); // fill differs in every word
		forever begin
			@(posedge clk);
			#1;
			dataAddrOk = 1'b0;
			dataDataOk = 1'b0;
			if (done)
				doneCount++;
			if (memPhase == 0 && dataReq === 1'b1) begin
				reqCount++;
				busAddr = dataAddr;
				busSize = dataSize;
				busStrb = dataWstrb;
				busData = dataWdata;
				busWr = dataWr;
				rngState = xorshift(rngState);
				waitLeft = rngState % 4;
				memPhase = 1;
			end
			if (memPhase == 1) begin
				if (!dataReq) begin
					$display("ERROR: dataReq dropped before dataAddrOk");
					busErrors++;
				end
				if (waitLeft == 0) begin
					dataAddrOk = 1'b1; // address taken at the next edge
					rngState = xorshift(rngState);
					waitLeft = rngState % 4;
					memPhase = 2;
				end else
					waitLeft--;
			end else if (memPhase == 2) begin
				if (dataReq) begin
					$display("ERROR: dataReq still high in the data phase");
					busErrors++;
				end
				if (waitLeft == 0) begin
					dataDataOk = 1'b1;
					dataRdata = mem[busAddr[5:2]];
					for (int b = 0; b < 4; b++)
						if (busWr && busStrb[b])
							mem[busAddr[5:2]][b*8 +: 8] = busData[b*8 +: 8];
					memPhase = 0;
				end else
					waitLeft--;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic checkWord(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			$display("FAILED %s: got %h, expected %h", name, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkStrobe(input string name, input strobe_t got, input strobe_t expected);
		if (got !== expected) begin
			$display("FAILED %s: got %h, expected %h", name, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkExc(input string name, input excCode_t got, input excCode_t expected);
		if (got !== expected) begin
			$display("FAILED %s: got %h, expected %h", name, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkSize(input string name, input busSize_t got, input busSize_t expected);
		if (got !== expected) begin
			$display("FAILED %s: got %h, expected %h", name, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("FAILED %s: got %h, expected %h", name, got, expected);
			errorCount++;
		end
	endtask

	task automatic noteError(input string msg);
		$display("ERROR: %s", msg);
		errorCount++;
	endtask

	// one access driven 1 ns after the edge
	task automatic runEntry(input int idx);
		entry_t e;
		int waited;
		int reqBefore;
		int doneBefore;
		int errBefore;
		e = vec[idx];
		errBefore = errorCount + busErrors;
		reqBefore = reqCount;
		doneBefore = doneCount;
		start = 1'b1;
		isStore = e.isStore;
		width = e.width;
		signExt = e.signExt;
		vAddr = e.addr;
		storeData = e.data;
		@(posedge clk);
		#1;
		start = !e.fault; // second start lands while busy
		vAddr = e.addr + 32'd8;
		waited = 0;
		while (!done && !excValid && waited < entryLimit) begin
			if (!busy)
				noteError("busy went low before done");
			@(posedge clk);
			#1;
			start = 1'b0;
			waited++;
		end
		if (waited >= entryLimit)
			noteError("no done or excValid within the cycle limit");
		else if (e.fault) begin
			if (!excValid)
				noteError("access finished on the bus instead of faulting");
			checkExc("excCode", excCode, e.code);
			checkWord("badVAddr", badVAddr, e.addr);
		end else begin
			if (!done)
				noteError("access faulted instead of finishing");
			if (busy)
				noteError("busy still high together with done");
			checkWord("dataAddr", busAddr, e.addr & physMask);
			checkSize("dataSize", busSize, sizeFor(e.width));
			checkStrobe("dataWstrb", busStrb, e.strb);
			checkFlag("dataWr", busWr, e.isStore);
			if (e.isStore)
				checkWord("dataWdata", busData, e.busData);
			else
				checkWord("loadData", loadData, e.result);
		end
		@(posedge clk);
		#1;
		if (done || excValid)
			noteError("done or excValid held for more than one cycle");
		@(posedge clk);
		#1;
		if (dataReq)
			noteError("bus request left open after the access");
		if (reqCount - reqBefore != (e.fault ? 0 : 1))
			noteError("wrong number of bus requests for one start");
		if (doneCount - doneBefore != (e.fault ? 0 : 1))
			noteError("wrong number of done pulses for one start");
		if (errorCount + busErrors == errBefore) begin
			passCount++;
			$display("test %0d %s %s at %h: ok", idx, e.isStore ? "store" : "load",
				e.width.name(), e.addr);
		end else
			$display("test %0d %s %s at %h: failed", idx, e.isStore ? "store" : "load",
				e.width.name(), e.addr);
	endtask

	initial begin
		reset = 1'b1;
		start = 1'b0;
		isStore = 1'b0;
		width = memWord;
		signExt = 1'b0;
		vAddr = '0;
		storeData = '0;
		errorCount = 0;
		passCount = 0;
		// kind, width, sign, address, data, fault, code, strobe, lanes, load result
		vec[0] = '{1'b1, memWord, 1'b0, 32'ha0000010, 32'h812345f6, 1'b0, '0, 4'hf,
			32'h812345f6, '0};
		vec[1] = '{1'b0, memWord, 1'b0, 32'ha0000010, '0, 1'b0, '0, 4'h0, '0, 32'h812345f6};
		vec[2] = '{1'b0, memHalf, 1'b1, 32'ha0000012, '0, 1'b0, '0, 4'h0, '0, 32'hffff8123};
		vec[3] = '{1'b0, memHalf, 1'b0, 32'ha0000010, '0, 1'b0, '0, 4'h0, '0, 32'h000045f6};
		vec[4] = '{1'b0, memByte, 1'b1, 32'ha0000010, '0, 1'b0, '0, 4'h0, '0, 32'hfffffff6};
		vec[5] = '{1'b0, memByte, 1'b0, 32'ha0000013, '0, 1'b0, '0, 4'h0, '0, 32'h00000081};
		vec[6] = '{1'b1, memHalf, 1'b0, 32'h80000022, 32'h1234beef, 1'b0, '0, 4'hc,
			32'hbeefbeef, '0};
		vec[7] = '{1'b0, memHalf, 1'b1, 32'h80000022, '0, 1'b0, '0, 4'h0, '0, 32'hffffbeef};
		vec[8] = '{1'b1, memByte, 1'b0, 32'ha0000031, 32'h000000a7, 1'b0, '0, 4'h2,
			32'ha7a7a7a7, '0};
		vec[9] = '{1'b0, memByte, 1'b1, 32'ha0000031, '0, 1'b0, '0, 4'h0, '0, 32'hffffffa7};
		vec[10] = '{1'b0, memByte, 1'b0, 32'ha0000031, '0, 1'b0, '0, 4'h0, '0, 32'h000000a7};
		vec[11] = '{1'b0, memHalf, 1'b1, 32'ha0000011, '0, 1'b1, 5'd4, 4'h0, '0, '0};
		vec[12] = '{1'b0, memWord, 1'b0, 32'ha0000012, '0, 1'b1, 5'd4, 4'h0, '0, '0};
		vec[13] = '{1'b1, memWord, 1'b0, 32'ha0000033, 32'h5a5a5a5a, 1'b1, 5'd5, 4'h0, '0, '0};
		vec[14] = '{1'b1, memHalf, 1'b0, 32'ha0000005, 32'h0000c3c3, 1'b1, 5'd5, 4'h0, '0, '0};
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;
		for (i = 0; i < numEntries; i++)
			runEntry(i);
		$display("%0d tests run, %0d passed, %0d failed", numEntries, passCount,
			numEntries - passCount);
		if (errorCount + busErrors == 0 && passCount == numEntries)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- sim.f
common/lsuPkg.sv
lsu/requestBuilder.sv
lsu/busSequencer.sv
lsu/loadAlign.sv
hdl/lsuTop.sv
tb/lsuTb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing
TOP      := lsuTb
FILELIST := sim.f
PASS     := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qF "$(PASS)"

clean:
	rm -rf obj_dir
